// File: Bender.yml
package:
  name: fetch_front_end

sources:
  - files:
      - hw/core_pkg.sv
      - hw/axil_pkg.sv
      - hw/fetch_axil_reader.sv
      - hw/instr_queue.sv
      - hw/branch_predict.sv
      - hw/fetch_unit.sv
      - hw/fetch_top.sv
  - target: test
    files:
      - tests/fetch_assertions.sv
      - tests/fetch_checker.sv
      - tests/fetch_tb.sv

// File: all.f
hw/core_pkg.sv
hw/axil_pkg.sv
hw/fetch_axil_reader.sv
hw/instr_queue.sv
hw/branch_predict.sv
hw/fetch_unit.sv
hw/fetch_top.sv
tests/fetch_assertions.sv
tests/fetch_checker.sv
tests/fetch_tb.sv

// File: hw/axil_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// read channels only, 32-bit address and data
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package axil_pkg;

	typedef logic [31:0] axil_addr_t;
	typedef logic [31:0] axil_data_t;
	typedef logic [2:0] prot_t;
	typedef logic [1:0] resp_t;

	localparam resp_t RESP_OKAY = 2'b00;
	localparam resp_t RESP_SLVERR = 2'b10;

	// unprivileged, secure, instruction access
	localparam prot_t ARPROT_INSTR = 3'b100;

	// read address channel, driven by the master
	typedef struct packed {
		axil_addr_t araddr;
		prot_t arprot;
		logic arvalid;
	} axil_ar_t;

	// read data channel, driven by the slave
	typedef struct packed {
		axil_data_t rdata;
		resp_t rresp;
		logic rvalid;
	} axil_r_t;

endpackage : axil_pkg

// File: hw/branch_predict.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// static rule: JAL and backward branches taken
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module branch_predict (
	input  core_pkg::instr_t  instr,
	input  core_pkg::data_t   pc,
	input  logic              valid,
	output logic              taken
);

	import core_pkg::*;

	opcode_t opcode;
	logic is_jal;
	logic is_back_branch;
	logic pc_aligned;

	assign opcode = instr[6:0];
	assign is_jal = (opcode == OPC_JAL);

	// B-type sign bit set means a negative offset
	assign is_back_branch = (opcode == OPC_BRANCH) && instr[IMM_SIGN_BIT];

	// a misaligned fetch address never predicts
	assign pc_aligned = (pc[1:0] == 2'b00);

	assign taken = valid && pc_aligned && (is_jal || is_back_branch);

endmodule : branch_predict

// File: hw/core_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32 only. Compressed (16-bit) encodings are not recognised
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package core_pkg;

	// datapath width
	localparam int XLEN = 32;

	// addresses and data words
	typedef logic [XLEN-1:0] data_t;

	// raw instruction word
	typedef logic [XLEN-1:0] instr_t;

	// major opcode field, bits 6:0
	typedef logic [6:0] opcode_t;

	// fixed encodings
	localparam instr_t ECALL = 32'h0000_0073;
	// addi x0, x0, 0
	localparam instr_t NOP = 32'h0000_0013;

	// opcodes the predictor looks at
	localparam opcode_t OPC_BRANCH = 7'b110_0011;
	localparam opcode_t OPC_JAL = 7'b110_1111;

	// immediate sign sits in the top bit for every format
	localparam int IMM_SIGN_BIT = XLEN - 1;

	// one instruction word in bytes
	localparam data_t INSTR_BYTES = 32'd4;

	// queue entry, also what the issue stage sees
	typedef struct packed {
		instr_t instr;
		data_t pc;
	} issue_t;

endpackage : core_pkg

// File: hw/fetch_axil_reader.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one read in flight; req is ignored while busy
// SLVERR completes like OKAY
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module fetch_axil_reader (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 req,
	input  core_pkg::data_t      req_addr,
	input  logic                 arready,
	input  axil_pkg::axil_r_t    r,
	output axil_pkg::axil_ar_t   ar,
	output logic                 rready,
	output logic                 busy,
	output logic                 done,
	output core_pkg::data_t      rdata
);

	import core_pkg::*;
	import axil_pkg::*;

	typedef enum logic [1:0] {
		RD_IDLE,
		RD_ADDR,
		RD_DATA
	} rd_state_t;

	rd_state_t state;
	data_t addr_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= RD_IDLE;
		end else begin
			unique case (state)
				RD_IDLE: if (req) state <= RD_ADDR;
				RD_ADDR: if (arready) state <= RD_DATA;
				RD_DATA: if (r.rvalid) state <= RD_IDLE;
				default: state <= RD_IDLE;
			endcase
		end
	end

	// address stays put from request until the AR handshake
	always_ff @(posedge clk) begin
		if (state == RD_IDLE && req) begin
			addr_q <= req_addr;
		end
	end

	assign ar.araddr = addr_q;
	assign ar.arprot = ARPROT_INSTR;
	assign ar.arvalid = (state == RD_ADDR);

	assign rready = (state == RD_DATA);
	assign busy = (state != RD_IDLE);

	// done in the R handshake cycle, word passed straight through
	assign done = (state == RD_DATA) && r.rvalid;
	assign rdata = r.rdata;

endmodule : fetch_axil_reader

// File: hw/fetch_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instr reads NOP whenever instr_valid is low
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module fetch_top #(
	parameter core_pkg::data_t BOOT_PC = 32'h0000_0000,
	parameter int QUEUE_AW = 4,
	parameter int ALMOST_FULL_MARGIN = 2
) (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                go,
	input  logic                stall,
	input  logic                flush,
	input  logic                pc_sel,
	input  core_pkg::data_t     pc_bj,
	input  core_pkg::instr_t    instr_w,
	output axil_pkg::axil_ar_t  ar,
	input  logic                arready,
	input  axil_pkg::axil_r_t   r,
	output logic                rready,
	output core_pkg::instr_t    instr,
	output core_pkg::data_t     pc_out,
	output core_pkg::data_t     pc_p4_out,
	output logic                instr_valid,
	output logic                taken
);

	import core_pkg::*;

	logic req, busy, done, push, queue_flush, empty, almost_full;
	data_t req_addr, rdata;
	issue_t push_entry, head;

	fetch_unit #(.BOOT_PC(BOOT_PC), .QUEUE_AW(QUEUE_AW)) fetch_unit_i (
		.clk, .rst_n, .go, .flush, .pc_sel, .pc_bj, .instr_w,
		.busy, .done, .rdata, .almost_full,
		.req, .req_addr, .push, .push_entry, .queue_flush
	);

	fetch_axil_reader fetch_axil_reader_i (
		.clk, .rst_n, .req, .req_addr, .arready, .r,
		.ar, .rready, .busy, .done, .rdata
	);

	// issue pops the head every cycle it is valid
	assign instr_valid = !empty && !stall;

	instr_queue #(.QUEUE_AW(QUEUE_AW), .ALMOST_FULL_MARGIN(ALMOST_FULL_MARGIN)) instr_queue_i (
		.clk, .rst_n, .flush(queue_flush), .push, .push_entry,
		.pop(instr_valid), .head, .empty, .almost_full
	);

	assign pc_out = head.pc;
	assign pc_p4_out = head.pc + INSTR_BYTES;
	assign instr = instr_valid ? head.instr : NOP;

	branch_predict branch_predict_i (.instr, .pc(pc_out), .valid(instr_valid), .taken);

endmodule : fetch_top

// File: hw/fetch_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// flush and pc_sel are expected together; a read in flight at a flush is dropped
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module fetch_unit #(
	parameter core_pkg::data_t BOOT_PC = 32'h0000_0000,
	parameter int QUEUE_AW = 4
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              go,
	input  logic              flush,
	input  logic              pc_sel,
	input  core_pkg::data_t   pc_bj,
	input  core_pkg::instr_t  instr_w,
	input  logic              busy,
	input  logic              done,
	input  core_pkg::data_t   rdata,
	input  logic              almost_full,
	output logic              req,
	output core_pkg::data_t   req_addr,
	output logic              push,
	output core_pkg::issue_t  push_entry,
	output logic              queue_flush
);

	import core_pkg::*;

	typedef enum logic [1:0] {
		S_IDLE,
		S_FETCH,
		S_HOLD,
		S_ECALL_WAIT
	} fetch_state_t;

	// the queue has to take the margin plus the word in flight
	if (QUEUE_AW < 2) begin : g_depth_check
		$error("fetch_unit: QUEUE_AW must be at least 2");
	end

	fetch_state_t state;
	fetch_state_t state_nxt;

	data_t pc;
	data_t redir_pc;
	logic redir_q;
	logic drop_q;
	logic ecall_push;

	// a done that belongs to a flushed read is neither pushed nor counted
	assign push = done && !drop_q && !flush;
	assign push_entry.instr = rdata;
	assign push_entry.pc = pc;
	assign ecall_push = push && (rdata == ECALL);

	assign queue_flush = flush;

	// no new request in a flush cycle, the redirect target is not latched yet
	assign req = (state == S_FETCH) && !busy && !almost_full && !flush;
	assign req_addr = redir_q ? redir_pc : pc;

	always_comb begin
		state_nxt = state;
		unique case (state)
			S_IDLE: begin
				if (go) state_nxt = S_FETCH;
			end
			S_FETCH: begin
				if (ecall_push) begin
					state_nxt = S_ECALL_WAIT;
				end else if (almost_full) begin
					state_nxt = S_HOLD;
				end
			end
			S_HOLD: begin
				if (ecall_push) begin
					state_nxt = S_ECALL_WAIT;
				end else if (!almost_full) begin
					state_nxt = S_FETCH;
				end
			end
			S_ECALL_WAIT: begin
				// core retired the ECALL
				if (instr_w == ECALL) state_nxt = S_IDLE;
			end
			default: state_nxt = S_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= S_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// pc is the address of the word being fetched
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= BOOT_PC;
		end else if (req && redir_q) begin
			pc <= redir_pc;
		end else if (push) begin
			pc <= pc + INSTR_BYTES;
		end
	end

	// redirect waits here until the next request picks it up
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			redir_q <= 1'b0;
		end else if (pc_sel) begin
			redir_q <= 1'b1;
		end else if (req) begin
			redir_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (pc_sel) begin
			redir_pc <= pc_bj;
		end
	end

	// response still on its way at the flush
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			drop_q <= 1'b0;
		end else if (flush && busy && !done) begin
			drop_q <= 1'b1;
		end else if (done) begin
			drop_q <= 1'b0;
		end
	end

endmodule : fetch_unit

// File: hw/instr_queue.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// depth is 2**QUEUE_AW; push when full and pop when empty are ignored
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module instr_queue #(
	parameter int QUEUE_AW = 4,
	parameter int ALMOST_FULL_MARGIN = 2
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              flush,
	input  logic              push,
	input  core_pkg::issue_t  push_entry,
	input  logic              pop,
	output core_pkg::issue_t  head,
	output logic              empty,
	output logic              almost_full
);

	import core_pkg::*;

	localparam int DEPTH = 1 << QUEUE_AW;

	typedef logic [QUEUE_AW-1:0] ptr_t;
	typedef logic [QUEUE_AW:0] cnt_t;

	issue_t mem [DEPTH];
	ptr_t rd_ptr;
	ptr_t wr_ptr;
	cnt_t count;
	cnt_t free_slots;
	logic full;
	logic do_push;
	logic do_pop;

	assign full = (count == cnt_t'(DEPTH));
	assign empty = (count == '0);
	assign do_push = push && !full && !flush;
	assign do_pop = pop && !empty && !flush;

	assign free_slots = cnt_t'(DEPTH) - count;
	assign almost_full = (free_slots <= cnt_t'(ALMOST_FULL_MARGIN));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else if (flush) begin
			// everything pending is thrown away in one edge
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) wr_ptr <= wr_ptr + 1'b1;
			if (do_pop) rd_ptr <= rd_ptr + 1'b1;
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_entry;
		end
	end

	// head is read combinationally, so a push shows up right after its edge
	assign head = mem[rd_ptr];

endmodule : instr_queue

// File: tests/fetch_assertions.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bound into reader and queue; each bind ties off the ports its target lacks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module fetch_assertions (
	input  logic                clk,
	input  logic                rst_n,
	input  axil_pkg::axil_ar_t  ar,
	input  logic                arready,
	input  axil_pkg::axil_r_t   r,
	input  logic                rready,
	input  logic                flush,
	input  logic                push,
	input  logic                full,
	input  logic                pop
);

	int violations = 0;
	int outstanding;
	int level;

	// reads accepted on AR but not yet answered on R
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			outstanding <= 0;
		end else begin
			outstanding <= outstanding + int'(ar.arvalid && arready) - int'(r.rvalid && rready);
		end
	end

	// entries held by the queue, counted from its pushes and pops
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			level <= 0;
		end else if (flush) begin
			level <= 0;
		end else begin
			level <= level + int'(push && !full) - int'(pop && level != 0);
		end
	end

	addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
		ar.arvalid && !arready |=> ar.arvalid && $stable(ar.araddr))
		else begin violations++; $error("read address moved or arvalid fell before arready"); end

	single_read: assert property (@(posedge clk) disable iff (!rst_n)
		ar.arvalid && arready |-> outstanding == 0)
		else begin violations++; $error("second read accepted while one is outstanding"); end

	no_push_full: assert property (@(posedge clk) disable iff (!rst_n) push |-> !full)
		else begin violations++; $error("push into a full instruction queue"); end

	valid_not_empty: assert property (@(posedge clk) disable iff (!rst_n) pop |-> level != 0)
		else begin violations++; $error("instr_valid high while the queue is empty"); end

endmodule : fetch_assertions

bind fetch_axil_reader fetch_assertions bus_assertions_i (
	.clk, .rst_n, .ar, .arready, .r, .rready,
	.flush(1'b0), .push(1'b0), .full(1'b0), .pop(1'b0)
);

bind instr_queue fetch_assertions queue_assertions_i (
	.clk, .rst_n, .ar('0), .arready(1'b0), .r('0), .rready(1'b0),
	.flush, .push, .full, .pop
);

// File: tests/fetch_checker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// redirect targets must be word aligned; test ids follow test_name
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module fetch_checker #(
	parameter core_pkg::data_t BOOT_PC = 32'h0000_1000,
	parameter core_pkg::data_t ECALL_ADDR = 32'h0000_8000
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              go,
	input  logic              stall,
	input  logic              flush,
	input  core_pkg::data_t   pc_bj,
	input  core_pkg::instr_t  instr,
	input  core_pkg::data_t   pc_out,
	input  core_pkg::data_t   pc_p4_out,
	input  logic              instr_valid,
	input  logic              taken,
	input  int                test_id,
	input  logic              test_end,
	input  logic              report,
	input  int                assert_fails,
	output int                issued,
	output logic              halted,
	output int                errors
);

	import core_pkg::*;

	data_t exp_pc = BOOT_PC;
	logic halted_q = 1'b0;
	int issue_count = 0;
	int test_issued = 0;
	int test_errors = 0;
	int error_total = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int taken_seen = 0;
	int fwd_branches = 0;

	assign issued = issue_count;
	assign halted = halted_q;
	assign errors = error_total + test_errors;

	// word layout of the test memory
	function automatic instr_t expected_word(data_t addr);
		if (addr == ECALL_ADDR) return ECALL;
		case (addr[4:2])
			3'd3: return {addr[5], addr[25:2], 7'b110_1111};
			3'd5: return {addr[6], addr[25:2], 7'b110_0011};
			default: return {addr[26:2], 7'b001_0011};
		endcase
	endfunction

	// JAL always, B-type only with a negative offset
	function automatic logic static_taken(instr_t w);
		return (w[6:0] == 7'b110_1111) || (w[6:0] == 7'b110_0011 && w[31]);
	endfunction

	function automatic string test_name(int id);
		case (id)
			1: return "sequential fetch";
			2: return "back-pressure";
			3: return "redirect";
			4: return "ecall halt";
			5: return "prediction";
			default: return "unknown";
		endcase
	endfunction

	task automatic compare(string name, logic [31:0] expected, logic [31:0] actual);
		if (expected !== actual) begin
			$display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
			test_errors++;
		end
	endtask

	task automatic finish_test();
		// the prediction run has to meet both outcomes
		if (test_id == 5 && (taken_seen == 0 || fwd_branches == 0)) begin
			$display("prediction test never saw both a taken and a not-taken branch");
			test_errors++;
		end
		$display("test %0d (%s): %s, %0d issued, %0d errors", test_id, test_name(test_id),
			(test_errors == 0) ? "ok" : "failed", test_issued, test_errors);
		tests_run++;
		if (test_errors != 0) tests_failed++;
		error_total += test_errors;
		test_errors = 0;
		test_issued = 0;
		taken_seen = 0;
		fwd_branches = 0;
	endtask

	always @(posedge clk) begin
		if (rst_n) begin
			if (go) halted_q = 1'b0;
			// a stalled issue stage takes nothing
			if (stall) compare("instr_valid", 32'd0, 32'(instr_valid));
			if (flush) begin
				// queue dropped and stream restarts at the target
				exp_pc = pc_bj;
			end else if (instr_valid) begin
				if (halted_q) begin
					$display("at %0t an instruction was issued while fetch was halted", $time);
					test_errors++;
				end
				compare("pc_out", exp_pc, pc_out);
				compare("instr", expected_word(exp_pc), instr);
				compare("pc_p4_out", exp_pc + 32'd4, pc_p4_out);
				compare("taken", 32'(static_taken(expected_word(exp_pc))), 32'(taken));
				if (taken) taken_seen++;
				if (instr[6:0] == 7'b110_0011 && !instr[31]) fwd_branches++;
				if (expected_word(exp_pc) == ECALL) halted_q = 1'b1;
				exp_pc = exp_pc + 32'd4;
				issue_count++;
				test_issued++;
			end else begin
				compare("instr", NOP, instr);
				compare("taken", 32'd0, 32'(taken));
			end
			if (test_end) finish_test();
			if (report) begin
				$display("%0d tests run, %0d failed, %0d check errors, %0d assertion failures",
					tests_run, tests_failed, error_total + test_errors, assert_fails);
			end
		end
	end

endmodule : fetch_checker

// File: tests/fetch_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ECALL exists only at ECALL_ADDR; random redirects stay far below it
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module fetch_tb;

	import core_pkg::*;
	import axil_pkg::*;

	localparam data_t BOOT_PC = 32'h0000_1000;
	localparam data_t ECALL_ADDR = 32'h0000_8000;
	localparam logic [31:0] SEED = 32'hb6e4;
	localparam int CLK_PERIOD = 4;
	localparam int SEQ_WORDS = 40;
	localparam int STALL_WORDS = 60;
	localparam int REDIRECTS = 6;
	localparam int REDIRECT_WORDS = 5;
	localparam int ECALL_LEAD = 8;
	localparam int PREDICT_WORDS = 48;
	localparam int TOTAL_WORDS = SEQ_WORDS + STALL_WORDS + REDIRECTS * REDIRECT_WORDS
		+ ECALL_LEAD + 2 + PREDICT_WORDS;
	// bus waits of 3 and 3, fsm overhead and one full stall run
	localparam int WORST_CYCLES_PER_WORD = 40;
	localparam int SLACK_CYCLES = 400;
	localparam int WATCHDOG_NS = (TOTAL_WORDS * WORST_CYCLES_PER_WORD + SLACK_CYCLES) * CLK_PERIOD;

	logic clk = 1'b0;
	logic rst_n;
	logic go;
	logic stall;
	logic flush;
	logic pc_sel;
	data_t pc_bj;
	instr_t instr_w;
	axil_ar_t ar;
	logic arready;
	axil_r_t r;
	logic rready;
	instr_t instr;
	data_t pc_out;
	data_t pc_p4_out;
	logic instr_valid;
	logic taken;

	logic stall_enable;
	logic [31:0] stim_rng;
	logic [31:0] stall_rng;
	logic [31:0] bus_rng;
	int test_id;
	logic test_end;
	logic report;
	int issued;
	logic halted;
	int check_errors;
	int assert_fails;

	always #(CLK_PERIOD / 2) clk = ~clk;

	fetch_top #(.BOOT_PC(BOOT_PC), .QUEUE_AW(4), .ALMOST_FULL_MARGIN(2)) fetch_top_i (
		.clk, .rst_n, .go, .stall, .flush, .pc_sel, .pc_bj, .instr_w,
		.ar, .arready, .r, .rready, .instr, .pc_out, .pc_p4_out, .instr_valid, .taken
	);

	assign assert_fails = fetch_top_i.fetch_axil_reader_i.bus_assertions_i.violations
		+ fetch_top_i.instr_queue_i.queue_assertions_i.violations;

	fetch_checker #(.BOOT_PC(BOOT_PC), .ECALL_ADDR(ECALL_ADDR)) checker_i (
		.clk, .rst_n, .go, .stall, .flush, .pc_bj, .instr, .pc_out, .pc_p4_out,
		.instr_valid, .taken, .test_id, .test_end, .report, .assert_fails,
		.issued, .halted, .errors(check_errors)
	);

	function automatic logic [31:0] lcg(logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// address-derived words, JAL in slot 3 and B-type in slot 5 of every 8
	function automatic instr_t memory_word(data_t addr);
		if (addr == ECALL_ADDR) return ECALL;
		case (addr[4:2])
			3'd3: return {addr[5], addr[25:2], 7'b110_1111};
			3'd5: return {addr[6], addr[25:2], 7'b110_0011};
			default: return {addr[26:2], 7'b001_0011};
		endcase
	endfunction

	task automatic wait_issued(int n);
		int target;
		target = issued + n;
		while (issued < target) @(negedge clk);
	endtask

	task automatic redirect(data_t target);
		@(negedge clk);
		flush = 1'b1;
		pc_sel = 1'b1;
		pc_bj = target;
		@(negedge clk);
		flush = 1'b0;
		pc_sel = 1'b0;
	endtask

	task automatic end_test(int id);
		@(negedge clk);
		test_id = id;
		test_end = 1'b1;
		@(negedge clk);
		test_end = 1'b0;
	endtask

	// AXI-Lite memory with 0 to 3 waits before arready and before rvalid
	initial begin : axi_memory
		data_t addr;
		arready = 1'b0;
		r = '0;
		forever begin
			@(negedge clk);
			if (rst_n && ar.arvalid) begin
				addr = ar.araddr;
				bus_rng = lcg(bus_rng);
				repeat (bus_rng[17:16]) @(negedge clk);
				arready = 1'b1;
				@(negedge clk);
				arready = 1'b0;
				repeat (bus_rng[19:18]) @(negedge clk);
				r.rdata = memory_word(addr);
				r.rresp = RESP_OKAY;
				r.rvalid = 1'b1;
				// data held until the reader takes it
				while (!rready) @(negedge clk);
				@(negedge clk);
				r.rvalid = 1'b0;
			end
		end
	end

	// stall runs of 1..30 cycles and free runs of 1..8
	initial begin : stall_driver
		int run;
		logic level;
		run = 0;
		level = 1'b0;
		stall = 1'b0;
		forever begin
			@(negedge clk);
			if (!stall_enable) begin
				stall = 1'b0;
			end else begin
				if (run == 0) begin
					stall_rng = lcg(stall_rng);
					level = ~level;
					run = level ? 1 + int'(stall_rng[20:16]) % 30 : 1 + int'(stall_rng[18:16]);
				end
				stall = level;
				run--;
			end
		end
	end

	initial begin : stimulus
		rst_n = 1'b0;
		go = 1'b0;
		flush = 1'b0;
		pc_sel = 1'b0;
		pc_bj = '0;
		instr_w = NOP;
		stall_enable = 1'b0;
		test_id = 0;
		test_end = 1'b0;
		report = 1'b0;
		stim_rng = SEED;
		stall_rng = lcg(SEED);
		bus_rng = lcg(lcg(SEED));
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		go = 1'b1;
		@(negedge clk);
		go = 1'b0;

		wait_issued(SEQ_WORDS);
		end_test(1);

		stall_enable = 1'b1;
		wait_issued(STALL_WORDS);
		end_test(2);

		repeat (REDIRECTS) begin
			stim_rng = lcg(stim_rng);
			repeat (stim_rng[19:16]) @(negedge clk);
			redirect(32'h0000_2000 + {22'd0, stim_rng[27:20], 2'b00});
			wait_issued(REDIRECT_WORDS);
		end
		end_test(3);

		// run into the ECALL then retire it and restart
		stall_enable = 1'b0;
		redirect(ECALL_ADDR - ECALL_LEAD * 4);
		while (!halted) @(negedge clk);
		repeat (20) @(negedge clk);
		instr_w = ECALL;
		@(negedge clk);
		instr_w = NOP;
		go = 1'b1;
		@(negedge clk);
		go = 1'b0;
		wait_issued(1);
		end_test(4);

		stall_enable = 1'b1;
		wait_issued(PREDICT_WORDS);
		stall_enable = 1'b0;
		end_test(5);

		@(negedge clk);
		report = 1'b1;
		@(negedge clk);
		report = 1'b0;
		@(negedge clk);
		if (check_errors == 0 && assert_fails == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("timeout: tests did not finish within %0d ns, fetch stopped making progress",
			WATCHDOG_NS);
		$display("Simulation failed");
		$finish;
	end

endmodule : fetch_tb
